// ==== Bender.yml ====
package:
  name: tx_frontend

export_include_dirs:
  - include

sources:
  - files:
      - verilog/tx_ctrl_pkg.sv
      - verilog/iq_sample_pkg.sv
      - verilog/tx_symbol_source.sv
      - verilog/tx_iq_fifo.sv
      - verilog/tx_on_detection.sv
      - verilog/tx_frontend_top.sv
  - target: test
    files:
      - bench/tb_tx_frontend.sv

// ==== bench/tb_tx_frontend.sv ====
// testbench for the transmit front end with random bursts, reference model and assertions
`timescale 1ns/1ns
`default_nettype none

`include "tx_timing_cfg.svh"

module tb_tx_frontend
    import tx_ctrl_pkg::*;
    import iq_sample_pkg::*;
();

    localparam int SCALE = `COUNT_SCALE;
    localparam int WAIT_LIMIT = 2000;
    localparam int NUM_TXN = 8;

    logic        clk;
    logic        rstn;
    logic        tx_req;
    tx_request_t req_data;
    logic        tx_ack;
    tx_timing_t  timing;
    logic        dac_ready = 1'b0;
    logic        dac_valid;
    iq_sample_t  dac_data;
    tx_status_t  status;

    // reference model state, sampled at the rising edge
    int   ready_pct = 100;
    logic req_issued = 1'b0;
    logic tx_req_q = 1'b0;
    logic bb_q = 1'b0;
    logic busy_expect = 1'b0;
    int   cyc = 0;
    int   taken = 0;
    int   end_pulses = 0;
    logic bb_armed = 1'b0;
    logic bb_ended = 1'b0;
    logic rf_opened = 1'b0;
    int   rf_on_t = 0;
    int   rf_off_t = 0;
    logic rf_expect;

    tx_frontend_top dut (
        .clk       (clk),
        .rstn      (rstn),
        .tx_req    (tx_req),
        .req_data  (req_data),
        .tx_ack    (tx_ack),
        .timing    (timing),
        .dac_ready (dac_ready),
        .dac_valid (dac_valid),
        .dac_data  (dac_data),
        .status    (status)
    );

    task automatic report_problem(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string test, input logic [63:0] expected,
                                   input logic [63:0] actual);
        report_problem($sformatf("Fail %s expected %0h actual %0h", test, expected, actual));
    endtask

    // i counts up from the base, q is its bitwise inverse
    function automatic iq_sample_t expected_sample(input logic [`IQ_WIDTH-1:0] base,
                                                   input int k);
        logic [`IQ_WIDTH-1:0] value;
        iq_sample_t s;
        value = base + k[`IQ_WIDTH-1:0];
        s.i = value;
        s.q = ~value;
        return s;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(negedge clk) begin
        if (!rstn) begin
            dac_ready = 1'b0;
        end else begin
            dac_ready = (($urandom % 100) < ready_pct);
        end
    end

    // RF window opens D*S+2 after the baseband rise, closes (D+E)*S+2 after the end pulse
    assign rf_expect = bb_armed && (cyc >= rf_on_t) &&
                       (!bb_ended || (rf_opened && cyc < rf_off_t));

    always @(posedge clk) begin
        cyc      <= cyc + 1;
        tx_req_q <= tx_req;
        bb_q     <= status.bb_ongoing;
        if (tx_req && !tx_req_q) begin
            taken       <= 0;
            end_pulses  <= 0;
            bb_armed    <= 1'b0;
            bb_ended    <= 1'b0;
            busy_expect <= 1'b1;
        end else begin
            if (dac_valid && dac_ready) begin
                taken <= taken + 1;
            end
            if (status.bb_end_pulse) begin
                end_pulses <= end_pulses + 1;
                bb_ended   <= 1'b1;
                rf_opened  <= (rf_on_t <= cyc);
                rf_off_t   <= cyc + (int'(timing.bb_rf_delay) + int'(timing.rf_end_ext)) * SCALE + 2;
            end
            if (tx_ack) begin
                busy_expect <= 1'b0;
            end
            if (status.bb_ongoing && !bb_q) begin
                bb_armed <= 1'b1;
                rf_on_t  <= cyc + int'(timing.bb_rf_delay) * SCALE + 2;
            end
        end
    end

    reset_idle: assert property (@(posedge clk) disable iff (!rstn)
        !req_issued |-> {tx_ack, dac_valid, status} == '0)
        else report_mismatch("reset_idle", 0, $sampled({tx_ack, dac_valid, status}));

    sample_value: assert property (@(posedge clk) disable iff (!rstn)
        dac_valid && dac_ready |-> dac_data == expected_sample(req_data.base, taken))
        else report_mismatch("sample_value", expected_sample(req_data.base, $sampled(taken)),
                             $sampled(dac_data));

    sample_count: assert property (@(posedge clk) disable iff (!rstn)
        $rose(tx_ack) |-> taken == int'(req_data.sample_count))
        else report_mismatch("sample_count", req_data.sample_count, $sampled(taken));

    extra_sample: assert property (@(posedge clk) disable iff (!rstn)
        dac_valid |-> taken < int'(req_data.sample_count))
        else report_problem("DAC offered more samples than the burst holds");

    ack_rise: assert property (@(posedge clk) disable iff (!rstn)
        $rose(tx_ack) |-> tx_req)
        else report_problem("tx_ack rose while tx_req was low");

    ack_fall: assert property (@(posedge clk) disable iff (!rstn)
        $fell(tx_ack) |-> !tx_req && !$past(tx_req))
        else report_problem("tx_ack fell before tx_req was released");

    core_busy: assert property (@(posedge clk) disable iff (!rstn)
        busy_expect |-> status.core_ongoing)
        else report_mismatch("core_busy", 1, $sampled(status.core_ongoing));

    core_idle: assert property (@(posedge clk) disable iff (!rstn)
        !tx_req && !tx_ack |-> !status.core_ongoing)
        else report_mismatch("core_idle", 0, $sampled(status.core_ongoing));

    // window opens on the edge that takes the first sample
    bb_covers_sample: assert property (@(posedge clk) disable iff (!rstn)
        dac_valid && dac_ready |=> status.bb_ongoing)
        else report_problem("DAC sample taken outside the baseband window");

    end_pulse_width: assert property (@(posedge clk) disable iff (!rstn)
        status.bb_end_pulse |=> !status.bb_end_pulse)
        else report_problem("bb_end_pulse lasted more than one cycle");

    end_pulse_inside: assert property (@(posedge clk) disable iff (!rstn)
        status.bb_end_pulse |-> status.bb_ongoing)
        else report_problem("bb_end_pulse outside the baseband window");

    end_pulse_once: assert property (@(posedge clk) disable iff (!rstn)
        status.bb_end_pulse |-> end_pulses == 0)
        else report_mismatch("end_pulse_once", 0, $sampled(end_pulses));

    end_pulse_seen: assert property (@(posedge clk) disable iff (!rstn)
        $fell(status.bb_ongoing) |-> end_pulses == 1)
        else report_mismatch("end_pulse_seen", 1, $sampled(end_pulses));

    rf_window: assert property (@(posedge clk) disable iff (!rstn)
        status.rf_ongoing == rf_expect)
        else report_mismatch("rf_window", $sampled(rf_expect), $sampled(status.rf_ongoing));

    initial begin
        int wait_cnt;
        void'($urandom(32'h1115_ecad));
        rstn     = 1'b0;
        tx_req   = 1'b0;
        req_data = '0;
        timing   = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        repeat (5) @(negedge clk);

        for (int n = 0; n < NUM_TXN; n++) begin
            req_data.sample_count = tx_count_t'(1 + ($urandom % 40));
            req_data.base         = tx_pattern_t'($urandom);
            timing.bb_rf_delay    = 8'($urandom % 7);
            timing.rf_end_ext     = 7'($urandom % 5);
            // light or heavy DAC back-pressure per burst
            ready_pct  = ($urandom % 2) ? 85 : 30;
            req_issued = 1'b1;
            tx_req     = 1'b1;
            wait_cnt = 0;
            while (!tx_ack) begin
                @(negedge clk);
                wait_cnt++;
                if (wait_cnt > WAIT_LIMIT) report_problem("timed out waiting for tx_ack to rise");
            end
            @(negedge clk);
            tx_req = 1'b0;
            wait_cnt = 0;
            while (tx_ack) begin
                @(negedge clk);
                wait_cnt++;
                if (wait_cnt > WAIT_LIMIT) report_problem("timed out waiting for tx_ack to fall");
            end
            wait_cnt = 0;
            while (status.bb_ongoing || status.rf_ongoing) begin
                @(negedge clk);
                wait_cnt++;
                if (wait_cnt > WAIT_LIMIT) report_problem("baseband or RF window never closed");
            end
        end

        repeat (10) @(negedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== include/tx_timing_cfg.svh ====
// configuration macros for the transmit timing block
`ifndef TX_TIMING_CFG_SVH
`define TX_TIMING_CFG_SVH

// clock cycles per microsecond-scale delay unit
`define COUNT_SCALE 4

// IQ FIFO entries
`define IQ_FIFO_DEPTH 16

// bits per I or Q component
`define IQ_WIDTH 12

// cycles from phy_tx_start to phy_tx_started
`define START_LATENCY 3

`endif

// ==== tx_frontend_top.f ====
+incdir+include
verilog/tx_ctrl_pkg.sv
verilog/iq_sample_pkg.sv
verilog/tx_symbol_source.sv
verilog/tx_iq_fifo.sv
verilog/tx_on_detection.sv
verilog/tx_frontend_top.sv
bench/tb_tx_frontend.sv

// ==== verilog/iq_sample_pkg.sv ====
// IQ component and IQ sample types
`default_nettype none

`include "tx_timing_cfg.svh"

package iq_sample_pkg;

    // one signed I or Q value
    typedef logic signed [`IQ_WIDTH-1:0] iq_component_t;

    // i sits in the upper half of the word
    typedef struct packed {
        iq_component_t i;
        iq_component_t q;
    } iq_sample_t;

endpackage

`default_nettype wire

// ==== verilog/tx_ctrl_pkg.sv ====
// transmit request, timing and status types
`default_nettype none

package tx_ctrl_pkg;

    localparam int TX_COUNT_W = 12;
    localparam int TX_BASE_W = 12;

    typedef logic [TX_COUNT_W-1:0] tx_count_t;
    typedef logic [TX_BASE_W-1:0] tx_pattern_t;

    // one host request, held stable while tx_req is high
    typedef struct packed {
        tx_count_t   sample_count;
        tx_pattern_t base;
    } tx_request_t;

    // both fields in microsecond-scale units
    typedef struct packed {
        logic [7:0] bb_rf_delay;
        logic [6:0] rf_end_ext;
    } tx_timing_t;

    typedef struct packed {
        logic core_ongoing;
        logic bb_ongoing;
        logic rf_ongoing;
        logic bb_end_pulse;
    } tx_status_t;

endpackage

`default_nettype wire

// ==== verilog/tx_frontend_top.sv ====
// top level with symbol source, IQ FIFO and transmit-on detector
`timescale 1ns/1ns
`default_nettype none

module tx_frontend_top
    import tx_ctrl_pkg::*;
    import iq_sample_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,

    input  logic        tx_req,
    input  tx_request_t req_data,
    output logic        tx_ack,

    input  tx_timing_t  timing,

    input  logic        dac_ready,
    output logic        dac_valid,
    output iq_sample_t  dac_data,

    output tx_status_t  status
);

    logic       fifo_full;
    logic       fifo_empty;
    logic       wr_en;
    iq_sample_t wr_data;
    logic       phy_tx_start;
    logic       phy_tx_started;
    logic       phy_tx_done;

    tx_symbol_source u_source (
        .clk            (clk),
        .rstn           (rstn),
        .tx_req         (tx_req),
        .req_data       (req_data),
        .tx_ack         (tx_ack),
        .full           (fifo_full),
        .empty          (fifo_empty),
        .wr_en          (wr_en),
        .wr_data        (wr_data),
        .phy_tx_start   (phy_tx_start),
        .phy_tx_started (phy_tx_started),
        .phy_tx_done    (phy_tx_done)
    );

    tx_iq_fifo u_fifo (
        .clk      (clk),
        .rstn     (rstn),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .full     (fifo_full),
        .empty    (fifo_empty),
        .rd_ready (dac_ready),
        .rd_valid (dac_valid),
        .rd_data  (dac_data)
    );

    tx_on_detection u_detect (
        .clk            (clk),
        .rstn           (rstn),
        .timing         (timing),
        .phy_tx_start   (phy_tx_start),
        .phy_tx_started (phy_tx_started),
        .phy_tx_done    (phy_tx_done),
        .iq_fifo_empty  (fifo_empty),
        .status         (status)
    );

endmodule

`default_nettype wire

// ==== verilog/tx_iq_fifo.sv ====
// synchronous IQ sample FIFO with empty flag and full back-pressure
`timescale 1ns/1ns
`default_nettype none

`include "tx_timing_cfg.svh"

module tx_iq_fifo
    import iq_sample_pkg::*;
#(
    parameter int DEPTH = `IQ_FIFO_DEPTH,
    parameter int WIDTH = 2 * `IQ_WIDTH
) (
    input  logic       clk,
    input  logic       rstn,

    input  logic       wr_en,
    input  iq_sample_t wr_data,
    output logic       full,
    output logic       empty,

    input  logic       rd_ready,
    output logic       rd_valid,
    output iq_sample_t rd_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign rd_valid = !empty;
    assign rd_data  = iq_sample_t'(mem[rd_ptr]);

    assign do_wr = wr_en && !full;
    assign do_rd = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= WIDTH'(wr_data);
        end
    end

    // pointers wrap explicitly so any depth works
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rstn) wr_en |-> !full
    ) else $error("write request while FIFO full");

endmodule

`default_nettype wire

// ==== verilog/tx_on_detection.sv ====
// core, baseband and RF busy windows plus baseband end pulse
`timescale 1ns/1ns
`default_nettype none

`include "tx_timing_cfg.svh"

module tx_on_detection
    import tx_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,

    input  tx_timing_t timing,

    input  logic       phy_tx_start,
    input  logic       phy_tx_started,
    input  logic       phy_tx_done,
    input  logic       iq_fifo_empty,

    output tx_status_t status
);

    localparam int CNT_W = 16;
    localparam logic [CNT_W-1:0] SCALE = CNT_W'(`COUNT_SCALE);

    logic             core_ongoing_q;
    logic             search;
    logic             empty_q;
    logic             bb_active;
    logic [3:0]       bb_tail;
    logic             bb_start_pulse;
    logic             bb_end_pulse;
    logic             iq_running;
    logic             rf_ongoing;
    logic [CNT_W-1:0] scale_d;
    logic [CNT_W-1:0] scale_de;
    logic [CNT_W-1:0] scale_de_p1;
    logic [CNT_W-1:0] delay_cnt;
    logic [CNT_W-1:0] core_idle_cnt;

    assign bb_start_pulse = bb_active && !bb_tail[0];
    assign bb_end_pulse   = !bb_active && bb_tail[0];

    assign status.core_ongoing = core_ongoing_q || phy_tx_start;
    // tail keeps the end pulse inside the baseband window
    assign status.bb_ongoing   = bb_active || (|bb_tail);
    assign status.rf_ongoing   = rf_ongoing;
    assign status.bb_end_pulse = bb_end_pulse;

    // scaled compare values, two register stages from the static timing
    always_ff @(posedge clk) begin
        scale_d     <= CNT_W'(timing.bb_rf_delay) * SCALE;
        scale_de    <= scale_d + CNT_W'(timing.rf_end_ext) * SCALE;
        scale_de_p1 <= scale_de + CNT_W'(1);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            core_ongoing_q <= 1'b0;
            search         <= 1'b0;
            empty_q        <= 1'b1;
            bb_active      <= 1'b0;
            bb_tail        <= '0;
            iq_running     <= 1'b0;
        end else begin
            empty_q <= iq_fifo_empty;
            bb_tail <= {bb_tail[2:0], bb_active};

            if (phy_tx_start) begin
                core_ongoing_q <= 1'b1;
            end else if (phy_tx_done) begin
                core_ongoing_q <= 1'b0;
            end

            // started arms the search for samples, done arms the search for drain
            if (phy_tx_started) begin
                search <= 1'b1;
            end else if (phy_tx_done) begin
                search <= 1'b0;
            end

            if (search) begin
                if (empty_q && !iq_fifo_empty) begin
                    bb_active <= 1'b1;
                end
            end else if (iq_fifo_empty) begin
                bb_active <= 1'b0;
            end

            if (bb_start_pulse) begin
                iq_running <= 1'b1;
            end else if (bb_end_pulse) begin
                iq_running <= 1'b0;
            end
        end
    end

    // delay counter restarts on both edges of the baseband window
    always_ff @(posedge clk) begin
        if (!rstn) begin
            delay_cnt  <= '0;
            rf_ongoing <= 1'b0;
        end else if (bb_start_pulse || bb_end_pulse) begin
            delay_cnt <= '0;
        end else begin
            if (delay_cnt != scale_de_p1) begin
                delay_cnt <= delay_cnt + 1'b1;
            end
            if (iq_running && delay_cnt == scale_d) begin
                rf_ongoing <= 1'b1;
            end else if (!iq_running && delay_cnt == scale_de) begin
                rf_ongoing <= 1'b0;
            end
        end
    end

    // cycles since the core went quiet, saturating
    always_ff @(posedge clk) begin
        if (!rstn || status.core_ongoing) begin
            core_idle_cnt <= '0;
        end else if (core_idle_cnt != '1) begin
            core_idle_cnt <= core_idle_cnt + 1'b1;
        end
    end

    // baseband only ends once done has been seen and the FIFO is drained
    a_end_after_drain: assert property (
        @(posedge clk) disable iff (!rstn)
        bb_end_pulse |-> iq_fifo_empty && !search
    ) else $error("bb_end_pulse before the FIFO drained");

    a_rf_closes: assert property (
        @(posedge clk) disable iff (!rstn)
        rf_ongoing |-> core_idle_cnt <= scale_de + CNT_W'(8)
    ) else $error("rf_ongoing held too long after core went idle");

endmodule

`default_nettype wire

// ==== verilog/tx_symbol_source.sv ====
// baseband symbol source with four-phase request handshake and burst writer
`timescale 1ns/1ns
`default_nettype none

`include "tx_timing_cfg.svh"

module tx_symbol_source
    import tx_ctrl_pkg::*;
    import iq_sample_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,

    input  logic        tx_req,
    input  tx_request_t req_data,
    output logic        tx_ack,

    input  logic        full,
    input  logic        empty,
    output logic        wr_en,
    output iq_sample_t  wr_data,

    output logic        phy_tx_start,
    output logic        phy_tx_started,
    output logic        phy_tx_done
);

    localparam int LAT = `START_LATENCY;
    localparam int WARM_W = $clog2(LAT + 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WARMUP,
        ST_BURST,
        ST_DRAIN,
        ST_ACK,
        ST_RELEASE
    } state_t;

    state_t            state;
    tx_request_t       req_q;
    logic [WARM_W-1:0] warm_cnt;
    tx_count_t         sample_idx;
    tx_pattern_t       pattern;

    // counting pattern, q is the bitwise inverse of i
    assign pattern = req_q.base + sample_idx;
    assign wr_data.i = iq_component_t'(pattern);
    assign wr_data.q = iq_component_t'(~pattern);

    assign wr_en = (state == ST_BURST) && !full;

    // request is captured once on acceptance
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && tx_req) begin
            req_q <= req_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state          <= ST_IDLE;
            tx_ack         <= 1'b0;
            phy_tx_start   <= 1'b0;
            phy_tx_started <= 1'b0;
            phy_tx_done    <= 1'b0;
            warm_cnt       <= '0;
            sample_idx     <= '0;
        end else begin
            phy_tx_start   <= 1'b0;
            phy_tx_started <= 1'b0;
            phy_tx_done    <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (tx_req) begin
                        phy_tx_start <= 1'b1;
                        warm_cnt     <= '0;
                        sample_idx   <= '0;
                        state        <= ST_WARMUP;
                    end
                end
                ST_WARMUP: begin
                    warm_cnt <= warm_cnt + 1'b1;
                    if (warm_cnt == WARM_W'(LAT - 1)) begin
                        phy_tx_started <= 1'b1;
                    end
                    // first write lands one cycle after started
                    if (warm_cnt == WARM_W'(LAT)) begin
                        state <= (req_q.sample_count == '0) ? ST_DRAIN : ST_BURST;
                    end
                end
                ST_BURST: begin
                    if (wr_en) begin
                        sample_idx <= sample_idx + 1'b1;
                        if (sample_idx == req_q.sample_count - 1'b1) begin
                            state <= ST_DRAIN;
                        end
                    end
                end
                ST_DRAIN: begin
                    // DAC has taken every sample
                    if (empty) begin
                        phy_tx_done <= 1'b1;
                        tx_ack      <= 1'b1;
                        state       <= ST_ACK;
                    end
                end
                ST_ACK, ST_RELEASE: begin
                    if (!tx_req) begin
                        tx_ack <= 1'b0;
                        state  <= ST_IDLE;
                    end else begin
                        state <= ST_RELEASE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // burst never writes past the requested sample count
    a_burst_in_bounds: assert property (
        @(posedge clk) disable iff (!rstn) wr_en |-> sample_idx < req_q.sample_count
    ) else $error("source wrote past the end of the burst");

    // host keeps the request up until it sees the ack
    a_req_held_until_ack: assert property (
        @(posedge clk) disable iff (!rstn) tx_req && !tx_ack |=> tx_req
    ) else $error("tx_req dropped before tx_ack");

endmodule

`default_nettype wire
